/* filelist.f */
hw/heapCommandPkg.sv
hw/heapStatusPkg.sv
hw/heapRequestIf.sv
hw/requestChecker.sv
hw/arrayAllocator.sv
hw/elementAlu.sv
hw/arrayStore.sv
hw/heapMemory.sv
verification/clockReset.sv
verification/heapMemoryTb.sv

/* hw/arrayAllocator.sv */
/*
 * Array allocator. Hands out array numbers from a running count or
 * from a LIFO of freed numbers, and keeps one allocation flag each.
 */
`timescale 1ns/1ps

module arrayAllocator #(
  parameter int arrayBits = 2
) (
  input  logic                 clock,
  input  logic                 resetN,
  heapRequestIf.sink           req,
  output logic [arrayBits-1:0] allocatedCount,
  output logic                 arrayAllocated,
  output logic                 allocFull,
  output logic [arrayBits-1:0] newArray
);

  localparam int arrayCount = 2 ** arrayBits;
  localparam logic [arrayBits-1:0] lastArray = arrayBits'(arrayCount - 1);

  logic [arrayBits-1:0]  freedStack [arrayCount];   // Freed array numbers
  logic [arrayBits-1:0]  freedTop;                  // Entries on the stack
  logic [arrayCount-1:0] allocated;
  logic                  stackEmpty;

  assign stackEmpty     = (freedTop == '0);
  assign newArray       = stackEmpty ? allocatedCount : freedStack[freedTop - 1'b1];
  assign allocFull      = stackEmpty && (allocatedCount == lastArray);
  assign arrayAllocated = allocated[req.array];

  // ----------------------------------------------------------------------
  // Count, stack pointer and flags
  // ----------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocatedCount <= '0;
      freedTop       <= '0;
      allocated      <= '0;
    end else if (req.accept) begin
      case (req.op)
        heapCommandPkg::opReset: begin
          allocatedCount <= '0;
          freedTop       <= '0;
          allocated      <= '0;
        end
        heapCommandPkg::opAlloc: begin
          if (stackEmpty) allocatedCount <= allocatedCount + 1'b1;   // Fresh number
          else            freedTop       <= freedTop - 1'b1;         // Reuse freed one
          allocated[newArray] <= 1'b1;
        end
        heapCommandPkg::opFree: begin
          freedTop              <= freedTop + 1'b1;
          allocated[req.array]  <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  // Stack contents
  always_ff @(posedge clock) begin
    if (req.accept && req.op == heapCommandPkg::opFree) freedStack[freedTop] <= req.array;
  end

endmodule

/* hw/arrayStore.sv */
/*
 * Array store. Holds the element memory and one size per array,
 * executes accepted commands and registers the command result.
 */
`timescale 1ns/1ps

module arrayStore #(
  parameter int arrayBits = 2,
  parameter int indexBits = 2,
  parameter int dataBits  = 12
) (
  input  logic                 clock,
  input  logic                 resetN,
  heapRequestIf.sink           req,
  input  logic [arrayBits-1:0] newArray,
  output logic [indexBits:0]   currentSize,
  output logic [dataBits-1:0]  result
);

  localparam int arrayCount  = 2 ** arrayBits;
  localparam int arrayLength = 2 ** indexBits;

  typedef logic [dataBits-1:0]  element_t;
  typedef logic [indexBits:0]   size_t;        // 0 up to arrayLength
  typedef logic [indexBits-1:0] index_t;

  element_t elements [arrayCount][arrayLength];
  size_t    sizes    [arrayCount];

  element_t oldValue;
  element_t newValue;
  element_t returnValue;
  index_t   pushIndex;
  index_t   topIndex;
  size_t    indexPlusOne;

  assign currentSize  = sizes[req.array];
  assign oldValue     = elements[req.array][req.index];
  assign pushIndex    = currentSize[indexBits-1:0];
  assign topIndex     = currentSize[indexBits-1:0] - 1'b1;   // Wraps for a full array
  assign indexPlusOne = {1'b0, req.index} + 1'b1;

  elementAlu #(
    .dataBits (dataBits)
  ) alu (
    .op          (req.op),
    .oldValue    (oldValue),
    .operand     (req.dataIn),
    .newValue    (newValue),
    .returnValue (returnValue)
  );

  // ----------------------------------------------------------------------
  // Sizes and result register
  // ----------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
      result <= '0;
    end else begin
      result <= '0;                                          // Rejected or idle
      if (req.accept) begin
        case (req.op)
          heapCommandPkg::opWrite: begin
            if (indexPlusOne > currentSize) sizes[req.array] <= indexPlusOne;
            result <= req.dataIn;
          end
          heapCommandPkg::opRead:   result <= oldValue;
          heapCommandPkg::opSize:   result <= element_t'(currentSize);
          heapCommandPkg::opInc,
          heapCommandPkg::opPush:   sizes[req.array] <= currentSize + 1'b1;
          heapCommandPkg::opDec:    sizes[req.array] <= currentSize - 1'b1;
          heapCommandPkg::opPop: begin
            sizes[req.array] <= currentSize - 1'b1;
            result           <= elements[req.array][topIndex];
          end
          heapCommandPkg::opResize: sizes[req.array] <= req.dataIn[indexBits:0];
          heapCommandPkg::opAlloc: begin
            sizes[newArray] <= '0;                           // New arrays start empty
            result          <= element_t'(newArray);
          end
          default: begin
            if (heapCommandPkg::isElementUpdate(req.op)) result <= returnValue;
          end
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // Element memory
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (req.accept) begin
      if (req.op == heapCommandPkg::opWrite) begin
        elements[req.array][req.index] <= req.dataIn;
      end else if (req.op == heapCommandPkg::opPush) begin
        elements[req.array][pushIndex] <= req.dataIn;    // Append at current size
      end else if (heapCommandPkg::isElementUpdate(req.op)) begin
        elements[req.array][req.index] <= newValue;
      end
    end
  end

endmodule

/* hw/elementAlu.sv */
/*
 * Element ALU. Computes the updated element and the value handed
 * back for the arithmetic and bitwise update commands.
 */
`timescale 1ns/1ps

module elementAlu #(
  parameter int dataBits = 12
) (
  input  heapCommandPkg::heapOp_t op,
  input  logic [dataBits-1:0]     oldValue,
  input  logic [dataBits-1:0]     operand,
  output logic [dataBits-1:0]     newValue,
  output logic [dataBits-1:0]     returnValue
);

  typedef logic [dataBits-1:0] element_t;

  element_t isZero;

  assign isZero = element_t'(oldValue == '0);

  always_comb begin
    case (op)
      heapCommandPkg::opAdd,
      heapCommandPkg::opAddAfter:   newValue = oldValue + operand;
      heapCommandPkg::opSubtract,
      heapCommandPkg::opSubAfter:   newValue = oldValue - operand;
      heapCommandPkg::opShiftLeft:  newValue = oldValue << operand;
      heapCommandPkg::opShiftRight: newValue = oldValue >> operand;
      heapCommandPkg::opNotLogical: newValue = isZero;              // 1 only for zero
      heapCommandPkg::opNot:        newValue = ~oldValue;
      heapCommandPkg::opOr:         newValue = oldValue | operand;
      heapCommandPkg::opXor:        newValue = oldValue ^ operand;
      heapCommandPkg::opAnd:        newValue = oldValue & operand;
      default:                      newValue = oldValue;
    endcase
  end

  // The "after" forms hand back the value before the update
  assign returnValue = (op == heapCommandPkg::opAddAfter || op == heapCommandPkg::opSubAfter)
                       ? oldValue : newValue;

endmodule

/* hw/heapCommandPkg.sv */
/*
 * Heap command set. Opcodes keep the classic heap numbering and
 * come with helpers that group them by the checks they need.
 */
package heapCommandPkg;

  typedef enum logic [4:0] {
    opReset      = 5'd1,
    opWrite      = 5'd2,
    opRead       = 5'd3,
    opSize       = 5'd4,
    opInc        = 5'd5,
    opDec        = 5'd6,
    opPush       = 5'd14,
    opPop        = 5'd15,
    opResize     = 5'd17,
    opAlloc      = 5'd18,
    opFree       = 5'd19,
    opAdd        = 5'd20,                   // Returns new value
    opAddAfter   = 5'd21,                   // Returns old value
    opSubtract   = 5'd22,
    opSubAfter   = 5'd23,
    opShiftLeft  = 5'd24,
    opShiftRight = 5'd25,
    opNotLogical = 5'd26,
    opNot        = 5'd27,
    opOr         = 5'd28,
    opXor        = 5'd29,
    opAnd        = 5'd30
  } heapOp_t;

  // Arithmetic and bitwise updates of one element
  function automatic logic isElementUpdate(heapOp_t op);
    return op inside {[opAdd:opAnd]};
  endfunction

  // Commands that touch an existing element
  function automatic logic isReadable(heapOp_t op);
    return (op == opRead) || isElementUpdate(op);
  endfunction

endpackage

/* hw/heapMemory.sv */
/*
 * Heap memory top level. Fixed-size numbered arrays with element
 * access, stack use and single-element updates, one command a cycle.
 */
`timescale 1ns/1ps

module heapMemory #(
  parameter int arrayBits = 2,
  parameter int indexBits = 2,
  parameter int dataBits  = 12
) (
  input  logic                      clock,
  input  logic                      resetN,
  input  logic                      start,
  input  heapCommandPkg::heapOp_t   op,
  input  logic [arrayBits-1:0]      array,
  input  logic [indexBits-1:0]      index,
  input  logic [dataBits-1:0]       dataIn,
  output logic                      done,
  output logic [dataBits-1:0]       result,
  output heapStatusPkg::heapError_t error
);

  logic [arrayBits-1:0] allocatedCount;
  logic                 arrayAllocated;
  logic                 allocFull;
  logic [arrayBits-1:0] newArray;
  logic [indexBits:0]   currentSize;

  heapRequestIf #(
    .arrayBits (arrayBits),
    .indexBits (indexBits),
    .dataBits  (dataBits)
  ) req ();

  assign req.start  = start;
  assign req.op     = op;
  assign req.array  = array;
  assign req.index  = index;
  assign req.dataIn = dataIn;

  requestChecker #(
    .arrayBits (arrayBits),
    .indexBits (indexBits),
    .dataBits  (dataBits)
  ) reqCheck (
    .clock          (clock),
    .resetN         (resetN),
    .req            (req.check),
    .allocatedCount (allocatedCount),
    .arrayAllocated (arrayAllocated),
    .allocFull      (allocFull),
    .currentSize    (currentSize),
    .done           (done),
    .error          (error)
  );

  arrayAllocator #(
    .arrayBits (arrayBits)
  ) allocator (
    .clock          (clock),
    .resetN         (resetN),
    .req            (req.sink),
    .allocatedCount (allocatedCount),
    .arrayAllocated (arrayAllocated),
    .allocFull      (allocFull),
    .newArray       (newArray)
  );

  arrayStore #(
    .arrayBits (arrayBits),
    .indexBits (indexBits),
    .dataBits  (dataBits)
  ) store (
    .clock       (clock),
    .resetN      (resetN),
    .req         (req.sink),
    .newArray    (newArray),
    .currentSize (currentSize),
    .result      (result)
  );

endmodule

/* hw/heapRequestIf.sv */
/*
 * Heap request bundle. Carries one command's fields from the top
 * level to the checker, allocator and store, plus the accept strobe.
 */
`timescale 1ns/1ps

interface heapRequestIf #(
  parameter int arrayBits = 2,
  parameter int indexBits = 2,
  parameter int dataBits  = 12
);
  logic                    start;       // Command valid this cycle
  heapCommandPkg::heapOp_t op;
  logic [arrayBits-1:0]    array;
  logic [indexBits-1:0]    index;
  logic [dataBits-1:0]     dataIn;
  logic                    accept;      // Legal command, state may change

  modport check (input start, op, array, index, dataIn, output accept);

  modport sink (input op, array, index, dataIn, accept);

endinterface

/* hw/heapStatusPkg.sv */
/*
 * Heap status codes reported with every done pulse.
 */
package heapStatusPkg;

  parameter int errorBits = 3;

  typedef enum logic [errorBits-1:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,             // Array number never handed out
    errFreed        = 3'd2,
    errOutOfBounds  = 3'd3,
    errEmpty        = 3'd4,
    errFull         = 3'd5,
    errTooLarge     = 3'd6,             // Resize beyond array length
    errOutOfMemory  = 3'd7
  } heapError_t;

endpackage

/* hw/requestChecker.sv */
/*
 * Request checker. Applies the legality rules to the presented
 * command, raises accept for legal ones and registers done/error.
 */
`timescale 1ns/1ps

module requestChecker #(
  parameter int arrayBits = 2,
  parameter int indexBits = 2,
  parameter int dataBits  = 12
) (
  input  logic                      clock,
  input  logic                      resetN,
  heapRequestIf.check               req,
  input  logic [arrayBits-1:0]      allocatedCount,
  input  logic                      arrayAllocated,
  input  logic                      allocFull,
  input  logic [indexBits:0]        currentSize,
  output logic                      done,
  output heapStatusPkg::heapError_t error
);

  localparam int arrayLength = 2 ** indexBits;
  localparam logic [indexBits:0] fullSize = {1'b1, {indexBits{1'b0}}};
  localparam logic [dataBits-1:0] maxSize = dataBits'(arrayLength);

  heapStatusPkg::heapError_t checkError;
  logic                      isPopLike;
  logic                      isPushLike;

  assign isPopLike  = (req.op == heapCommandPkg::opPop) || (req.op == heapCommandPkg::opDec);
  assign isPushLike = (req.op == heapCommandPkg::opPush) || (req.op == heapCommandPkg::opInc);

  // ----------------------------------------------------------------------
  // Legality, first failing rule wins
  // ----------------------------------------------------------------------
  always_comb begin
    checkError = heapStatusPkg::errNone;
    if (req.op == heapCommandPkg::opAlloc) begin
      if (allocFull) checkError = heapStatusPkg::errOutOfMemory;
    end else if (req.op != heapCommandPkg::opReset) begin
      if (req.array >= allocatedCount) begin
        checkError = heapStatusPkg::errNotAllocated;
      end else if (!arrayAllocated) begin
        checkError = heapStatusPkg::errFreed;
      end else if (heapCommandPkg::isReadable(req.op) && {1'b0, req.index} >= currentSize) begin
        checkError = heapStatusPkg::errOutOfBounds;
      end else if (isPopLike && currentSize == '0) begin
        checkError = heapStatusPkg::errEmpty;
      end else if (isPushLike && currentSize == fullSize) begin
        checkError = heapStatusPkg::errFull;
      end else if (req.op == heapCommandPkg::opResize && req.dataIn > maxSize) begin
        checkError = heapStatusPkg::errTooLarge;
      end
    end
  end

  assign req.accept = req.start && (checkError == heapStatusPkg::errNone);

  // Response one cycle after the command
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done  <= 1'b0;
      error <= heapStatusPkg::errNone;
    end else begin
      done  <= req.start;
      error <= req.start ? checkError : heapStatusPkg::errNone;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the heap memory simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module heapMemoryTb \
  -f filelist.f -o simHeap > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/simHeap > sim.log 2>&1
cat sim.log

grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

/* verification/clockReset.sv */
/*
 * Testbench clock and reset. Free-running clock and an active-low
 * reset held for a fixed number of cycles.
 */
`timescale 1ns/1ps

module clockReset #(
  parameter int periodNs    = 20,
  parameter int resetCycles = 8
) (
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #(periodNs / 2) clock = ~clock;
  end

  initial begin
    resetN = 1'b0;
    repeat (resetCycles) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;                                 // Release away from the rising edge
  end

endmodule

/* verification/heapMemoryTb.sv */
/*
 * Heap memory testbench. Drives commands on falling edges, predicts
 * result and error with a reference model and checks them with assertions.
 */
`timescale 1ns/1ps

module heapMemoryTb;

  localparam int commandBudget = 120;             // Upper bound on issued commands
  localparam int watchdogNs    = (8 + commandBudget) * 20 + 2000;

  logic clock;
  logic resetN;
  logic start;
  heapCommandPkg::heapOp_t op;
  logic [1:0]  array;
  logic [1:0]  index;
  logic [11:0] dataIn;
  logic        done;
  logic [11:0] result;
  heapStatusPkg::heapError_t error;

  // Model state
  int          mSize [4];
  logic [11:0] mElem [4][4];
  bit          mAlloc [4];
  int          mCount;
  int          mFreed [$];
  logic [31:0] lfsr = 32'hd3ba;

  // Expected response, pending until the command is sampled
  logic [11:0] pendResult;
  logic [11:0] checkResult;
  heapStatusPkg::heapError_t pendError;
  heapStatusPkg::heapError_t checkError;
  string pendName;
  string checkName;

  heapCommandPkg::heapOp_t updateOps [11] = '{
    heapCommandPkg::opAdd, heapCommandPkg::opAddAfter, heapCommandPkg::opSubtract,
    heapCommandPkg::opSubAfter, heapCommandPkg::opShiftLeft, heapCommandPkg::opShiftRight,
    heapCommandPkg::opNot, heapCommandPkg::opNotLogical, heapCommandPkg::opOr,
    heapCommandPkg::opXor, heapCommandPkg::opAnd
  };

  clockReset clockGen (.clock(clock), .resetN(resetN));

  heapMemory UUT (
    .clock(clock), .resetN(resetN), .start(start), .op(op), .array(array),
    .index(index), .dataIn(dataIn), .done(done), .result(result), .error(error)
  );

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  assert property (@(posedge clock) disable iff (!resetN) start |=> done)
    else begin
      $display("done did not follow a command by one cycle");
      $display("STATUS: FAIL");
      $fatal(1, "missing done");
    end

  assert property (@(posedge clock) disable iff (!resetN) !start |=> !done)
    else begin
      $display("done was raised without a command");
      $display("STATUS: FAIL");
      $fatal(1, "spurious done");
    end

  assert property (@(posedge clock) disable iff (!resetN)
                   done |-> (result == checkResult && error == checkError))
    else begin
      $display("Error in %s: expected result %0h error %0d, actual result %0h error %0d",
               checkName, checkResult, checkError, $sampled(result), $sampled(error));
      $display("STATUS: FAIL");
      $fatal(1, "response mismatch");
    end

  initial begin
    #(watchdogNs);
    $display("Simulation timed out before all commands finished");
    $display("STATUS: FAIL");
    $fatal(1, "watchdog");
  end

  // Fibonacci LFSR, one step per bit taken
  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr     = {lfsr[30:0], feedback};
      value    = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic bit isUpdate(input heapCommandPkg::heapOp_t cmd);
    return cmd inside {heapCommandPkg::opAdd, heapCommandPkg::opAddAfter,
                       heapCommandPkg::opSubtract, heapCommandPkg::opSubAfter,
                       heapCommandPkg::opShiftLeft, heapCommandPkg::opShiftRight,
                       heapCommandPkg::opNot, heapCommandPkg::opNotLogical,
                       heapCommandPkg::opOr, heapCommandPkg::opXor, heapCommandPkg::opAnd};
  endfunction

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  task automatic predict(input heapCommandPkg::heapOp_t cmd, input int arr, input int idx,
                         input logic [11:0] value, output logic [11:0] res,
                         output heapStatusPkg::heapError_t err);
    logic [11:0] oldV;
    logic [11:0] newV;
    int          newArr;
    err = heapStatusPkg::errNone;
    res = '0;
    if (cmd == heapCommandPkg::opAlloc) begin
      if (mFreed.size() == 0 && mCount == 3) err = heapStatusPkg::errOutOfMemory;
    end else if (cmd != heapCommandPkg::opReset) begin
      if (arr >= mCount) err = heapStatusPkg::errNotAllocated;
      else if (!mAlloc[arr]) err = heapStatusPkg::errFreed;
      else if ((cmd == heapCommandPkg::opRead || isUpdate(cmd)) && idx >= mSize[arr])
        err = heapStatusPkg::errOutOfBounds;
      else if ((cmd == heapCommandPkg::opPop || cmd == heapCommandPkg::opDec) && mSize[arr] == 0)
        err = heapStatusPkg::errEmpty;
      else if ((cmd == heapCommandPkg::opPush || cmd == heapCommandPkg::opInc) && mSize[arr] == 4)
        err = heapStatusPkg::errFull;
      else if (cmd == heapCommandPkg::opResize && value > 4) err = heapStatusPkg::errTooLarge;
    end
    if (err != heapStatusPkg::errNone) return;
    case (cmd)
      heapCommandPkg::opReset: begin
        mCount = 0;
        mFreed.delete();
        foreach (mAlloc[i]) mAlloc[i] = 1'b0;
      end
      heapCommandPkg::opAlloc: begin
        if (mFreed.size() > 0) begin
          newArr = mFreed.pop_back();                         // Last freed comes back first
        end else begin
          newArr = mCount;
          mCount++;
        end
        mAlloc[newArr] = 1'b1;
        mSize[newArr]  = 0;
        res = 12'(newArr);
      end
      heapCommandPkg::opFree: begin
        mFreed.push_back(arr);
        mAlloc[arr] = 1'b0;
      end
      heapCommandPkg::opWrite: begin
        mElem[arr][idx] = value;
        if (idx + 1 > mSize[arr]) mSize[arr] = idx + 1;
        res = value;
      end
      heapCommandPkg::opRead:   res = mElem[arr][idx];
      heapCommandPkg::opSize:   res = 12'(mSize[arr]);
      heapCommandPkg::opInc:    mSize[arr]++;
      heapCommandPkg::opDec:    mSize[arr]--;
      heapCommandPkg::opResize: mSize[arr] = int'(value);
      heapCommandPkg::opPush: begin
        mElem[arr][mSize[arr]] = value;
        mSize[arr]++;
      end
      heapCommandPkg::opPop: begin
        mSize[arr]--;
        res = mElem[arr][mSize[arr]];
      end
      default: begin
        oldV = mElem[arr][idx];
        case (cmd)
          heapCommandPkg::opAdd, heapCommandPkg::opAddAfter:      newV = oldV + value;
          heapCommandPkg::opSubtract, heapCommandPkg::opSubAfter: newV = oldV - value;
          heapCommandPkg::opShiftLeft:  newV = oldV << value;
          heapCommandPkg::opShiftRight: newV = oldV >> value;
          heapCommandPkg::opNot:        newV = ~oldV;
          heapCommandPkg::opNotLogical: newV = (oldV == 0) ? 12'd1 : 12'd0;
          heapCommandPkg::opOr:         newV = oldV | value;
          heapCommandPkg::opXor:        newV = oldV ^ value;
          default:                      newV = oldV & value;
        endcase
        mElem[arr][idx] = newV;
        res = (cmd == heapCommandPkg::opAddAfter || cmd == heapCommandPkg::opSubAfter)
              ? oldV : newV;
      end
    endcase
  endtask

  // One command per falling edge
  task automatic issue(input heapCommandPkg::heapOp_t cmd, input int arr, input int idx,
                       input logic [11:0] value, input string name);
    logic [11:0] expResult;
    heapStatusPkg::heapError_t expError;
    @(negedge clock);
    checkResult = pendResult;
    checkError  = pendError;
    checkName   = pendName;
    start  = 1'b1;
    op     = cmd;
    array  = 2'(arr);
    index  = 2'(idx);
    dataIn = value;
    predict(cmd, arr, idx, value, expResult, expError);
    pendResult = expResult;
    pendError  = expError;
    pendName   = name;
  endtask

  task automatic idle();
    @(negedge clock);
    checkResult = pendResult;
    checkError  = pendError;
    checkName   = pendName;
    start = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    int k;
    start = 1'b0;
    op = heapCommandPkg::opReset;
    array = '0;
    index = '0;
    dataIn = '0;
    mCount = 0;
    foreach (mSize[i]) mSize[i] = 0;
    foreach (mAlloc[i]) mAlloc[i] = 1'b0;
    pendResult = '0;
    pendError = heapStatusPkg::errNone;
    pendName = "reset";
    checkResult = '0;
    checkError = heapStatusPkg::errNone;
    checkName = "reset";
    @(posedge resetN);

    repeat (4) issue(heapCommandPkg::opAlloc, 0, 0, 0, "allocFirst");

    for (int i = 0; i < 4; i++) issue(heapCommandPkg::opWrite, 0, i, randomBits(12), "write");
    for (int i = 0; i < 4; i++) issue(heapCommandPkg::opRead, 0, i, 0, "read");
    repeat (5) issue(heapCommandPkg::opPush, 1, 0, randomBits(12), "push");
    issue(heapCommandPkg::opSize, 1, 0, 0, "stackSize");
    repeat (5) issue(heapCommandPkg::opPop, 1, 0, 0, "pop");
    issue(heapCommandPkg::opRead, 1, 0, 0, "readEmpty");
    issue(heapCommandPkg::opRead, 2, 2, 0, "readBeyond");

    issue(heapCommandPkg::opFree, 1, 0, 0, "free");
    issue(heapCommandPkg::opRead, 1, 0, 0, "readFreed");
    issue(heapCommandPkg::opAlloc, 0, 0, 0, "allocReuse");
    issue(heapCommandPkg::opRead, 3, 0, 0, "readUnallocated");

    for (int pass = 0; pass < 2; pass++) begin
      foreach (updateOps[j]) begin
        k = int'(randomBits(2));
        if (updateOps[j] inside {heapCommandPkg::opShiftLeft, heapCommandPkg::opShiftRight})
          issue(updateOps[j], 0, k, randomBits(4), "shift");
        else
          issue(updateOps[j], 0, k, randomBits(12), "update");
        issue(heapCommandPkg::opRead, 0, k, 0, "readUpdated");
      end
    end

    issue(heapCommandPkg::opInc, 2, 0, 0, "inc");
    issue(heapCommandPkg::opSize, 2, 0, 0, "sizeAfterInc");
    issue(heapCommandPkg::opDec, 2, 0, 0, "dec");
    issue(heapCommandPkg::opDec, 2, 0, 0, "decEmpty");
    issue(heapCommandPkg::opResize, 2, 0, 3, "resize");
    issue(heapCommandPkg::opSize, 2, 0, 0, "sizeAfterResize");
    issue(heapCommandPkg::opResize, 2, 0, 5, "resizeTooLarge");
    issue(heapCommandPkg::opResize, 2, 0, 4, "resizeFull");
    issue(heapCommandPkg::opInc, 2, 0, 0, "incFull");
    issue(heapCommandPkg::opReset, 0, 0, 0, "resetCommand");
    issue(heapCommandPkg::opAlloc, 0, 0, 0, "allocAfterReset");
    repeat (3) idle();

    $display("STATUS: PASS");
    $finish;
  end

endmodule
